/* logic/axi_lite_pkg.sv */
package axi_lite_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

    // master to slave
    typedef struct packed {
        logic              ar_valid;
        logic [addr_w-1:0] ar_addr;
        logic [2:0]        ar_prot;
        logic              aw_valid;
        logic [addr_w-1:0] aw_addr;
        logic [2:0]        aw_prot;
        logic              w_valid;
        logic [data_w-1:0] w_data;
        logic [strb_w-1:0] w_strb;
        logic              r_ready;
        logic              b_ready;
    } axi_req_t;

    // slave to master
    typedef struct packed {
        logic              ar_ready;
        logic              aw_ready;
        logic              w_ready;
        logic              r_valid;
        logic [data_w-1:0] r_data;
        axi_resp_t         r_resp;
        logic              b_valid;
        axi_resp_t         b_resp;
    } axi_rsp_t;

endpackage

/* logic/mem_pkg.sv */
package mem_pkg;

    // one state per channel, waiting for the master to take the response
    typedef enum logic {
        st_idle = 1'b0,
        st_resp = 1'b1
    } chan_state_t;

    // which master holds the slave
    typedef enum logic {
        own_m0 = 1'b0,
        own_m1 = 1'b1
    } arb_owner_t;

    // word layout of the backing store
    localparam int byte_lanes = 4;
    localparam int lane_bits  = 8;

endpackage

/* logic/mem_array.sv */
module mem_array #(
    parameter int depth_words = 256,
    localparam int idx_w = $clog2(depth_words),
    localparam int word_w = mem_pkg::byte_lanes * mem_pkg::lane_bits
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [idx_w-1:0]               waddr,
    input  logic [word_w-1:0]              wdata,
    input  logic [mem_pkg::byte_lanes-1:0] wstrb,
    input  logic                           re,
    input  logic [idx_w-1:0]               raddr,
    output logic [word_w-1:0]              rdata
);

    logic [mem_pkg::byte_lanes-1:0][mem_pkg::lane_bits-1:0] mem [depth_words];

    // byte-enable write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < mem_pkg::byte_lanes; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][i] <= wdata[i*mem_pkg::lane_bits +: mem_pkg::lane_bits];
                end
            end
        end
    end

    // registered read, holds between enables
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* logic/axi_mem_slave.sv */
module axi_mem_slave #(
    parameter int depth_words = 256,
    localparam int idx_w = $clog2(depth_words)
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      flush,
    input  axi_lite_pkg::axi_req_t                    req,
    output axi_lite_pkg::axi_rsp_t                    rsp,
    output logic                                      mem_we,
    output logic [idx_w-1:0]                          mem_waddr,
    output logic [axi_lite_pkg::data_w-1:0]           mem_wdata,
    output logic [axi_lite_pkg::strb_w-1:0]           mem_wstrb,
    output logic                                      mem_re,
    output logic [idx_w-1:0]                          mem_raddr,
    input  logic [axi_lite_pkg::data_w-1:0]           mem_rdata
);

    mem_pkg::chan_state_t    rd_state;
    mem_pkg::chan_state_t    wr_state;
    axi_lite_pkg::axi_resp_t r_resp_q;
    axi_lite_pkg::axi_resp_t b_resp_q;

    logic [axi_lite_pkg::addr_w-1:0] ar_word;
    logic [axi_lite_pkg::addr_w-1:0] aw_word;
    logic ar_ok;
    logic aw_ok;
    logic ar_hs;
    logic wr_hs;
    logic r_done;
    logic b_done;

    // byte address to word index
    assign ar_word = req.ar_addr >> $clog2(mem_pkg::byte_lanes);
    assign aw_word = req.aw_addr >> $clog2(mem_pkg::byte_lanes);
    assign ar_ok   = ar_word < axi_lite_pkg::addr_w'(depth_words);
    assign aw_ok   = aw_word < axi_lite_pkg::addr_w'(depth_words);

    assign ar_hs  = req.ar_valid && (rd_state == mem_pkg::st_idle);
    assign wr_hs  = req.aw_valid && req.w_valid && (wr_state == mem_pkg::st_idle);
    assign r_done = (rd_state == mem_pkg::st_resp) && req.r_ready;
    assign b_done = (wr_state == mem_pkg::st_resp) && req.b_ready;

    // array is only touched for beats that land inside it
    assign mem_re    = ar_hs && ar_ok;
    assign mem_raddr = ar_word[idx_w-1:0];
    assign mem_we    = wr_hs && aw_ok;
    assign mem_waddr = aw_word[idx_w-1:0];
    assign mem_wdata = req.w_data;
    assign mem_wstrb = req.w_strb;

    always_ff @(posedge clk) begin
        if (!reset) begin
            rd_state <= mem_pkg::st_idle;
            wr_state <= mem_pkg::st_idle;
        end else begin
            // flush drops whatever read is in flight
            if (flush) begin
                rd_state <= mem_pkg::st_idle;
            end else if (ar_hs) begin
                rd_state <= mem_pkg::st_resp;
            end else if (r_done) begin
                rd_state <= mem_pkg::st_idle;
            end

            if (wr_hs) begin
                wr_state <= mem_pkg::st_resp;
            end else if (b_done) begin
                wr_state <= mem_pkg::st_idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            r_resp_q <= ar_ok ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
        end
        if (wr_hs) begin
            b_resp_q <= aw_ok ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
        end
    end

    always_comb begin
        rsp.ar_ready = (rd_state == mem_pkg::st_idle);
        rsp.aw_ready = (wr_state == mem_pkg::st_idle);
        rsp.w_ready  = (wr_state == mem_pkg::st_idle);
        rsp.r_valid  = (rd_state == mem_pkg::st_resp);
        // error reads return zero, not the stale array output
        rsp.r_data   = (r_resp_q == axi_lite_pkg::resp_slverr) ? '0 : mem_rdata;
        rsp.r_resp   = r_resp_q;
        rsp.b_valid  = (wr_state == mem_pkg::st_resp);
        rsp.b_resp   = b_resp_q;
    end

endmodule

/* logic/axi_lite_arbiter.sv */
module axi_lite_arbiter (
    input  logic                   clk,
    input  logic                   reset,
    input  axi_lite_pkg::axi_req_t m0_req,
    input  axi_lite_pkg::axi_req_t m1_req,
    output axi_lite_pkg::axi_rsp_t m0_rsp,
    output axi_lite_pkg::axi_rsp_t m1_rsp,
    output axi_lite_pkg::axi_req_t s_req,
    input  axi_lite_pkg::axi_rsp_t s_rsp
);

    mem_pkg::arb_owner_t last_q;
    mem_pkg::arb_owner_t grant;
    logic busy_q;
    logic grant_valid;
    logic m0_want;
    logic m1_want;
    logic slave_idle;
    logic locked;
    logic accept;

    assign m0_want = m0_req.ar_valid || (m0_req.aw_valid && m0_req.w_valid);
    assign m1_want = m1_req.ar_valid || (m1_req.aw_valid && m1_req.w_valid);

    // slave readies depend on its state only, so no loop through here
    assign slave_idle = s_rsp.ar_ready && s_rsp.aw_ready;
    assign locked     = busy_q && !slave_idle;

    always_comb begin
        grant       = last_q;
        grant_valid = 1'b1;
        if (locked) begin
            grant = last_q;
        end else if (m0_want && m1_want) begin
            // contested, hand over to the other side
            grant = (last_q == mem_pkg::own_m0) ? mem_pkg::own_m1 : mem_pkg::own_m0;
        end else if (m0_want) begin
            grant = mem_pkg::own_m0;
        end else if (m1_want) begin
            grant = mem_pkg::own_m1;
        end else begin
            grant_valid = 1'b0;
        end
    end

    always_comb begin
        s_req  = '0;
        m0_rsp = '0;
        m1_rsp = '0;
        if (grant_valid) begin
            if (grant == mem_pkg::own_m0) begin
                s_req  = m0_req;
                m0_rsp = s_rsp;
            end else begin
                s_req  = m1_req;
                m1_rsp = s_rsp;
            end
        end
    end

    assign accept = (s_req.ar_valid && s_rsp.ar_ready) ||
                    (s_req.aw_valid && s_req.w_valid && s_rsp.aw_ready);

    always_ff @(posedge clk) begin
        if (!reset) begin
            // so the first contest goes to m0
            last_q <= mem_pkg::own_m1;
            busy_q <= 1'b0;
        end else if (grant_valid && accept) begin
            last_q <= grant;
            busy_q <= 1'b1;
        end else if (slave_idle) begin
            busy_q <= 1'b0;
        end
    end

endmodule

/* logic/mem_subsystem_top.sv */
module mem_subsystem_top #(
    parameter int depth_words = 256,
    localparam int idx_w = $clog2(depth_words)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  axi_lite_pkg::axi_req_t m0_req,
    input  axi_lite_pkg::axi_req_t m1_req,
    output axi_lite_pkg::axi_rsp_t m0_rsp,
    output axi_lite_pkg::axi_rsp_t m1_rsp
);

    axi_lite_pkg::axi_req_t s_req;
    axi_lite_pkg::axi_rsp_t s_rsp;

    logic                            mem_we;
    logic [idx_w-1:0]                mem_waddr;
    logic [axi_lite_pkg::data_w-1:0] mem_wdata;
    logic [axi_lite_pkg::strb_w-1:0] mem_wstrb;
    logic                            mem_re;
    logic [idx_w-1:0]                mem_raddr;
    logic [axi_lite_pkg::data_w-1:0] mem_rdata;

    axi_lite_arbiter arb_i (
        .clk    (clk),
        .reset  (reset),
        .m0_req (m0_req),
        .m1_req (m1_req),
        .m0_rsp (m0_rsp),
        .m1_rsp (m1_rsp),
        .s_req  (s_req),
        .s_rsp  (s_rsp)
    );

    axi_mem_slave #(.depth_words(depth_words)) slave_i (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .req       (s_req),
        .rsp       (s_rsp),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata)
    );

    mem_array #(.depth_words(depth_words)) array_i (
        .clk   (clk),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata),
        .wstrb (mem_wstrb),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata)
    );

endmodule

/* tb/mem_subsystem_assert.sv */
module mem_subsystem_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input axi_lite_pkg::axi_req_t req,
    input axi_lite_pkg::axi_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    // read response waits for r_ready or a flush
    r_hold: assert property (@(posedge clk) disable iff (!reset)
        rsp.r_valid && !req.r_ready && !flush |=>
            rsp.r_valid && $stable(rsp.r_data) && $stable(rsp.r_resp))
        else $error("r_valid, r_data or r_resp changed before r_ready");

    b_hold: assert property (@(posedge clk) disable iff (!reset)
        rsp.b_valid && !req.b_ready |=> rsp.b_valid && $stable(rsp.b_resp))
        else $error("b_valid or b_resp changed before b_ready");

    // accepted read answers next cycle and blocks further reads
    ar_blocked: assert property (@(posedge clk) disable iff (!reset)
        req.ar_valid && rsp.ar_ready && !flush |=> rsp.r_valid && !rsp.ar_ready)
        else $error("accepted read gave no r_valid next cycle or left ar_ready high");

endmodule

bind axi_mem_slave mem_subsystem_assert assert_i (
    .clk   (clk),
    .reset (reset),
    .flush (flush),
    .req   (req),
    .rsp   (rsp)
);

/* tb/tb_mem_subsystem.sv */
module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int depth_words    = 256;
    localparam int idx_w          = $clog2(depth_words);
    localparam int n_rows         = 19;
    localparam int timeout_cycles = 50 * n_rows;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_t;

    typedef struct packed {
        mem_pkg::arb_owner_t master;
        op_t                 op;
        logic [31:0]         addr;
        logic [31:0]         data;
        logic [3:0]          strb;
        logic [3:0]          delay;
        logic                both;
        logic                do_flush;
    } row_t;

    // master, op, byte address, data, strobe, ready delay, both masters, flush
    // both masters: m0 uses the address, m1 the next word with random write data
    localparam row_t rows [n_rows] = '{
        '{mem_pkg::own_m0, op_write, 32'h0000_0010, 32'h0bad_c0de, 4'hf, 4'd0, 1'b1, 1'b0},
        '{mem_pkg::own_m0, op_write, 32'h0000_0000, 32'h1122_3344, 4'hf, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_read,  32'h0000_0000, 32'h0,         4'h0, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_write, 32'h0000_0004, 32'ha5a5_5a5a, 4'hf, 4'd1, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_read,  32'h0000_0004, 32'h0,         4'h0, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_write, 32'h0000_0000, 32'hdead_beef, 4'h5, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_read,  32'h0000_0000, 32'h0,         4'h0, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_write, 32'h0000_0008, 32'h0102_0304, 4'hf, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_write, 32'h0000_0008, 32'hf0e0_d0c0, 4'ha, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_read,  32'h0000_0008, 32'h0,         4'h0, 4'd2, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_read,  32'h0000_0010, 32'h0,         4'h0, 4'd1, 1'b1, 1'b0},
        '{mem_pkg::own_m0, op_write, 32'h0000_0400, 32'hffff_ffff, 4'hf, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_read,  32'h0000_0400, 32'h0,         4'h0, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_read,  32'h0000_0000, 32'h0,         4'h0, 4'd0, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_write, 32'h0000_000c, 32'h1234_5678, 4'hf, 4'd3, 1'b0, 1'b0},
        '{mem_pkg::own_m0, op_read,  32'h0000_000c, 32'h0,         4'h0, 4'd3, 1'b0, 1'b0},
        '{mem_pkg::own_m1, op_read,  32'h0000_0004, 32'h0,         4'h0, 4'd0, 1'b0, 1'b1},
        '{mem_pkg::own_m0, op_write, 32'h0000_0018, 32'h55aa_55aa, 4'hf, 4'd1, 1'b1, 1'b0},
        '{mem_pkg::own_m1, op_read,  32'h0000_0018, 32'h0,         4'h0, 4'd0, 1'b1, 1'b0}
    };

    logic clk;
    logic reset;
    logic flush;
    axi_lite_pkg::axi_req_t req [2];
    axi_lite_pkg::axi_rsp_t rsp [2];
    logic [31:0] model [depth_words];
    mem_pkg::arb_owner_t grant_log [$];
    mem_pkg::arb_owner_t last_winner;
    int errors;

    mem_subsystem_top #(.depth_words(depth_words)) dut_i (
        .clk    (clk),
        .reset  (reset),
        .flush  (flush),
        .m0_req (req[0]),
        .m1_req (req[1]),
        .m0_rsp (rsp[0]),
        .m1_rsp (rsp[1])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic write_word(input int m, input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int delay);
        axi_lite_pkg::axi_resp_t exp_resp;
        logic [31:0] word;
        logic [idx_w-1:0] idx;
        string p;
        p = $sformatf("m%0d.", m);
        word = addr >> 2;
        idx = word[idx_w-1:0];
        @(posedge clk);
        req[m].aw_valid <= 1'b1;
        req[m].aw_addr  <= addr;
        req[m].w_valid  <= 1'b1;
        req[m].w_data   <= data;
        req[m].w_strb   <= strb;
        @(negedge clk);
        while (!(rsp[m].aw_ready && rsp[m].w_ready)) @(negedge clk);
        grant_log.push_back((m == 0) ? mem_pkg::own_m0 : mem_pkg::own_m1);
        // merge enabled bytes, out of range leaves the model alone
        exp_resp = axi_lite_pkg::resp_slverr;
        if (word < depth_words) begin
            exp_resp = axi_lite_pkg::resp_okay;
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    model[idx][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        @(posedge clk);
        req[m].aw_valid <= 1'b0;
        req[m].w_valid  <= 1'b0;
        @(negedge clk);
        check_value({p, "b_valid"}, 32'd1, 32'(rsp[m].b_valid));
        check_value({p, "b_resp"}, 32'(exp_resp), 32'(rsp[m].b_resp));
        repeat (delay) begin
            @(posedge clk);
            @(negedge clk);
            check_value({p, "b_valid"}, 32'd1, 32'(rsp[m].b_valid));
            check_value({p, "aw_ready"}, 32'd0, 32'({rsp[m].aw_ready, rsp[m].w_ready}));
            check_value("other master rsp", 32'd0,
                        32'({rsp[1-m].ar_ready, rsp[1-m].aw_ready, rsp[1-m].b_valid}));
        end
        @(posedge clk);
        req[m].b_ready <= 1'b1;
        @(negedge clk);
        check_value({p, "b_valid"}, 32'd1, 32'(rsp[m].b_valid));
        @(posedge clk);
        req[m].b_ready <= 1'b0;
    endtask

    task automatic read_word(input int m, input logic [31:0] addr, input int delay,
                             input logic flush_it);
        axi_lite_pkg::axi_resp_t exp_resp;
        logic [31:0] exp_data;
        logic [31:0] word;
        logic [idx_w-1:0] idx;
        string p;
        p = $sformatf("m%0d.", m);
        word = addr >> 2;
        idx = word[idx_w-1:0];
        @(posedge clk);
        req[m].ar_valid <= 1'b1;
        req[m].ar_addr  <= addr;
        @(negedge clk);
        while (!rsp[m].ar_ready) @(negedge clk);
        check_value({p, "r_valid"}, 32'd0, 32'(rsp[m].r_valid));
        grant_log.push_back((m == 0) ? mem_pkg::own_m0 : mem_pkg::own_m1);
        exp_data = '0;
        exp_resp = axi_lite_pkg::resp_slverr;
        if (word < depth_words) begin
            exp_data = model[idx];
            exp_resp = axi_lite_pkg::resp_okay;
        end
        @(posedge clk);
        req[m].ar_valid <= 1'b0;
        if (flush_it) begin
            flush <= 1'b1;
        end
        // one cycle after the AR handshake
        @(negedge clk);
        check_value({p, "r_valid"}, 32'd1, 32'(rsp[m].r_valid));
        check_value({p, "r_data"}, exp_data, rsp[m].r_data);
        check_value({p, "r_resp"}, 32'(exp_resp), 32'(rsp[m].r_resp));
        if (flush_it) begin
            @(posedge clk);
            flush <= 1'b0;
            @(negedge clk);
            check_value({p, "r_valid after flush"}, 32'd0, 32'(rsp[m].r_valid));
        end else begin
            repeat (delay) begin
                @(posedge clk);
                @(negedge clk);
                check_value({p, "r_valid"}, 32'd1, 32'(rsp[m].r_valid));
                check_value({p, "r_data"}, exp_data, rsp[m].r_data);
                check_value({p, "ar_ready"}, 32'd0, 32'(rsp[m].ar_ready));
                check_value("other master rsp", 32'd0,
                            32'({rsp[1-m].ar_ready, rsp[1-m].aw_ready, rsp[1-m].r_valid}));
            end
            @(posedge clk);
            req[m].r_ready <= 1'b1;
            @(negedge clk);
            check_value({p, "r_data"}, exp_data, rsp[m].r_data);
            @(posedge clk);
            req[m].r_ready <= 1'b0;
        end
    endtask

    task automatic apply_row(input row_t row);
        mem_pkg::arb_owner_t first_exp;
        logic [31:0] extra;
        int m;
        int d;
        m = (row.master == mem_pkg::own_m0) ? 0 : 1;
        d = int'(row.delay);
        grant_log.delete();
        if (row.both) begin
            // round robin, the side after the last winner goes first
            first_exp = (last_winner == mem_pkg::own_m0) ? mem_pkg::own_m1 : mem_pkg::own_m0;
            extra = $urandom;
            fork
                begin
                    if (row.op == op_write) begin
                        write_word(0, row.addr, row.data, row.strb, d);
                    end else begin
                        read_word(0, row.addr, d, 1'b0);
                    end
                end
                begin
                    if (row.op == op_write) begin
                        write_word(1, row.addr + 32'd4, extra, row.strb, d);
                    end else begin
                        read_word(1, row.addr + 32'd4, d, 1'b0);
                    end
                end
            join
            check_value("first grant", 32'(first_exp), 32'(grant_log[0]));
            last_winner = grant_log[1];
        end else begin
            if (row.op == op_write) begin
                write_word(m, row.addr, row.data, row.strb, d);
            end else if (row.do_flush) begin
                read_word(m, row.addr, 0, 1'b1);
                read_word(m, row.addr, d, 1'b0);
            end else begin
                read_word(m, row.addr, d, 1'b0);
            end
            last_winner = row.master;
        end
    endtask

    initial begin
        #(timeout_cycles * 100);
        $display("watchdog expired after %0d cycles, DUT stopped responding", timeout_cycles);
        $display("errors: %0d", errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(81));
        errors = 0;
        // arbiter reset state, m0 takes the first contest
        last_winner = mem_pkg::own_m1;
        reset = 1'b0;
        flush = 1'b0;
        req[0] = '0;
        req[1] = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
logic/axi_lite_pkg.sv
logic/mem_pkg.sv
logic/mem_array.sv
logic/axi_mem_slave.sv
logic/axi_lite_arbiter.sv
logic/mem_subsystem_top.sv
tb/mem_subsystem_assert.sv
tb/tb_mem_subsystem.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mem_subsystem
FILELIST = files.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Regression failed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
